//--- flist.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/bypass.sv
src/execute_stage.sv
src/retire_stage.sv
src/regfile.sv
src/datapath.sv
sim/tb_datapath.sv

//--- run.sh
#!/bin/sh
# build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module tb_datapath -o sim_datapath
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_datapath > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- sim/tb_datapath.sv
`timescale 1ns/10ps

module tb_datapath import isa_pkg::*; ();

    localparam word_t RESET_PC   = 32'h0000_0000;
    localparam int    PROG_LEN   = 200;
    localparam int    MAX_CYCLES = PROG_LEN * 8 + 100;

    logic      clk;
    logic      rst;
    word_t     iaddr;
    logic      ihit;
    word_t     idata;
    logic      retire_valid;
    word_t     retire_pc;
    logic      retire_we;
    reg_addr_t retire_waddr;
    word_t     retire_wdata;

    word_t     prog [PROG_LEN];
    word_t     model_regs [32];
    word_t     model_pc;
    reg_addr_t recent [4];
    int        cycles;
    logic      done;

    datapath #(.RESET_PC(RESET_PC)) datapath_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // no-ops everywhere past the program
    function automatic word_t imem_read(word_t addr);
        word_t idx;
        idx = (addr - RESET_PC) >> 2;
        if (idx < PROG_LEN) begin
            return prog[idx[7:0]];
        end
        return 32'h0000_0000;
    endfunction

    // half of the sources reuse one of the last four destinations
    function automatic reg_addr_t pick_src();
        if ($urandom_range(1, 0) == 1) begin
            return recent[2'($urandom_range(3, 0))];
        end
        return reg_addr_t'($urandom_range(15, 0));
    endfunction

    task automatic push_dest(input reg_addr_t rd);
        recent[3] = recent[2];
        recent[2] = recent[1];
        recent[1] = recent[0];
        recent[0] = rd;
    endtask

    task automatic build_program();
        logic [5:0]  r_fns [8] = '{fn_addu, fn_subu, fn_and, fn_or,
                                   fn_xor, fn_nor, fn_slt, fn_sltu};
        logic [5:0]  i_ops [6] = '{op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui};
        int unsigned kind;
        int unsigned sub;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = $urandom_range(9, 0);
            rs   = pick_src();
            rt   = pick_src();
            rd   = reg_addr_t'($urandom_range(15, 0));
            imm  = 16'($urandom);
            if (kind < 4) begin
                sub     = $urandom_range(7, 0);
                prog[i] = {op_special, rs, rt, rd, 5'd0, r_fns[sub[2:0]]};
                push_dest(rd);
            end else if (kind < 7) begin
                sub     = $urandom_range(5, 0);
                prog[i] = {i_ops[sub[2:0]], rs, rd, imm};
                push_dest(rd);
            end else if (kind < 9) begin
                // equal operands make a good share of beq taken
                if ($urandom_range(2, 0) == 0) begin
                    rt = rs;
                end
                prog[i] = {(kind == 7) ? op_beq : op_bne, rs, rt,
                           16'($urandom_range(3, 0))};
            end else if ($urandom_range(1, 0) == 0) begin
                // add with overflow trap is not implemented
                prog[i] = {op_special, rs, rt, rd, 5'd0, 6'h20};
            end else begin
                // lw is not implemented
                prog[i] = {6'h23, rs, rt, imm};
            end
        end
    endtask

    // reference MIPS behavior for one instruction per call in program order
    task automatic model_step(output logic we, output reg_addr_t waddr, output word_t wdata);
        word_t instr;
        word_t a;
        word_t b;
        word_t simm;
        word_t zimm;
        word_t next_pc;
        logic  writes;
        instr   = imem_read(model_pc);
        a       = model_regs[instr[25:21]];
        b       = model_regs[instr[20:16]];
        simm    = {{16{instr[15]}}, instr[15:0]};
        zimm    = {16'h0000, instr[15:0]};
        next_pc = model_pc + 32'd4;
        writes  = 1'b1;
        waddr   = instr[20:16];
        wdata   = 32'h0;
        case (instr[31:26])
            op_special: begin
                waddr = instr[15:11];
                case (instr[5:0])
                    fn_addu: wdata = a + b;
                    fn_subu: wdata = a - b;
                    fn_and:  wdata = a & b;
                    fn_or:   wdata = a | b;
                    fn_xor:  wdata = a ^ b;
                    fn_nor:  wdata = ~(a | b);
                    fn_slt:  wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fn_sltu: wdata = (a < b) ? 32'd1 : 32'd0;
                    default: writes = 1'b0;
                endcase
            end
            op_addiu: wdata = a + simm;
            op_slti:  wdata = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            op_andi:  wdata = a & zimm;
            op_ori:   wdata = a | zimm;
            op_xori:  wdata = a ^ zimm;
            op_lui:   wdata = {instr[15:0], 16'h0000};
            op_beq, op_bne: begin
                writes = 1'b0;
                // no delay slot
                if ((a == b) == (instr[31:26] == op_beq)) begin
                    next_pc = next_pc + (simm << 2);
                end
            end
            default:  writes = 1'b0;
        endcase
        we = writes && waddr != 5'd0;
        if (we) begin
            model_regs[waddr] = wdata;
        end
        model_pc = next_pc;
    endtask

    task automatic check_value(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        logic      exp_we;
        reg_addr_t exp_waddr;
        word_t     exp_wdata;
        void'($urandom(32'ha036));
        rst      = 1'b1;
        ihit     = 1'b0;
        idata    = 32'h0;
        done     = 1'b0;
        cycles   = 0;
        model_pc = RESET_PC;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int r = 0; r < 4; r++) begin
            recent[r] = '0;
        end
        build_program();

        repeat (8) begin
            @(posedge clk);
            #1;
            check_value("retire_valid in reset", 32'(retire_valid), 32'd0);
        end
        check_value("iaddr after reset", iaddr, RESET_PC);
        rst = 1'b0;

        while (!done && cycles < MAX_CYCLES) begin
            // about one miss in four with junk on the data bus during a miss
            ihit = ($urandom_range(3, 0) != 0);
            if (ihit) begin
                idata = imem_read(iaddr);
            end else begin
                idata = $urandom;
            end
            @(posedge clk);
            #1;
            cycles++;
            if (retire_valid) begin
                check_value("retire_pc", retire_pc, model_pc);
                model_step(exp_we, exp_waddr, exp_wdata);
                check_value("retire_we", 32'(retire_we), 32'(exp_we));
                if (exp_we) begin
                    check_value("retire_waddr", 32'(retire_waddr), 32'(exp_waddr));
                    check_value("retire_wdata", retire_wdata, exp_wdata);
                end
                if (model_pc >= RESET_PC + 32'(PROG_LEN * 4)) begin
                    done = 1'b1;
                end
            end
        end

        if (done) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout: end of program not retired after %0d cycles", cycles);
        end
    end

endmodule

//--- src/bypass.sv
`timescale 1ns/10ps

module bypass import isa_pkg::*, pipe_pkg::*; (
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      exec_valid,
    input  reg_addr_t exec_waddr,
    input  logic      exec_we,
    input  logic      retire_valid,
    input  reg_addr_t retire_waddr,
    input  logic      retire_we,
    output fwd_src_t  fwd_a,
    output fwd_src_t  fwd_b
);

    logic exec_live;
    logic retire_live;

    // youngest producer wins
    function automatic fwd_src_t pick(logic exec_match, logic retire_match);
        if (exec_match) begin
            return fwd_exec;
        end else if (retire_match) begin
            return fwd_retire;
        end
        return fwd_rf;
    endfunction

    // r0 never has a producer
    assign exec_live   = exec_valid && exec_we && exec_waddr != 5'd0;
    assign retire_live = retire_valid && retire_we && retire_waddr != 5'd0;

    assign fwd_a = pick(exec_live && exec_waddr == rs_addr,
                        retire_live && retire_waddr == rs_addr);
    assign fwd_b = pick(exec_live && exec_waddr == rt_addr,
                        retire_live && retire_waddr == rt_addr);

endmodule

//--- src/datapath.sv
`timescale 1ns/10ps

module datapath import isa_pkg::*, pipe_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst,
    output word_t     iaddr,
    input  logic      ihit,
    input  word_t     idata,
    output logic      retire_valid,
    output word_t     retire_pc,
    output logic      retire_we,
    output reg_addr_t retire_waddr,
    output word_t     retire_wdata
);

    // F/D
    logic      fd_valid;
    word_t     fd_pc;
    word_t     fd_instr;
    // D/E
    logic      de_valid;
    word_t     de_pc;
    alu_op_t   de_op;
    br_kind_t  de_br;
    word_t     de_src_a;
    word_t     de_src_b;
    word_t     de_imm_sel;
    reg_addr_t de_waddr;
    logic      de_we;
    // E/R
    logic      er_valid;
    word_t     er_pc;
    logic      er_we;
    reg_addr_t er_waddr;
    word_t     er_wdata;

    // register file and bypass
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rf_rdata_a;
    word_t     rf_rdata_b;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    fwd_src_t  fwd_a;
    fwd_src_t  fwd_b;
    logic      exec_valid;
    reg_addr_t exec_waddr;
    logic      exec_we;
    word_t     exec_wdata;

    logic      redirect;
    word_t     redirect_pc;

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_i (.*);

    decode_stage decode_stage_i (.squash(redirect), .*);

    bypass bypass_i (.*);

    execute_stage execute_stage_i (.*);

    retire_stage retire_stage_i (.*);

    regfile regfile_i (.*);

endmodule

//--- src/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      squash,
    input  logic      fd_valid,
    input  word_t     fd_pc,
    input  word_t     fd_instr,
    input  word_t     rf_rdata_a,
    input  word_t     rf_rdata_b,
    input  fwd_src_t  fwd_a,
    input  fwd_src_t  fwd_b,
    input  word_t     exec_wdata,
    input  word_t     retire_wdata,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    output logic      de_valid,
    output word_t     de_pc,
    output alu_op_t   de_op,
    output br_kind_t  de_br,
    output word_t     de_src_a,
    output word_t     de_src_b,
    output word_t     de_imm_sel,
    output reg_addr_t de_waddr,
    output logic      de_we
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    reg_addr_t   rd_addr;
    reg_addr_t   waddr;
    alu_op_t     op;
    br_kind_t    br;
    logic        is_rtype;
    logic        sign_ext;
    logic        use_imm;
    word_t       imm;
    word_t       opnd_a;
    word_t       opnd_b;

    function automatic word_t fwd_mux(fwd_src_t sel, word_t rf_val, word_t ex_val,
                                      word_t rt_val);
        case (sel)
            fwd_exec:   return ex_val;
            fwd_retire: return rt_val;
            default:    return rf_val;
        endcase
    endfunction

    assign opcode  = fd_instr[31:26];
    assign rs_addr = fd_instr[25:21];
    assign rt_addr = fd_instr[20:16];
    assign rd_addr = fd_instr[15:11];
    assign imm16   = fd_instr[15:0];
    assign funct   = fd_instr[5:0];

    always_comb begin
        op = alu_nop;
        br = br_none;
        case (opcode)
            op_special: begin
                case (funct)
                    fn_addu: op = alu_add;
                    fn_subu: op = alu_sub;
                    fn_and:  op = alu_and;
                    fn_or:   op = alu_or;
                    fn_xor:  op = alu_xor;
                    fn_nor:  op = alu_nor;
                    fn_slt:  op = alu_slt;
                    fn_sltu: op = alu_sltu;
                    default: op = alu_nop;
                endcase
            end
            op_addiu: op = alu_add;
            op_slti:  op = alu_slt;
            op_andi:  op = alu_and;
            op_ori:   op = alu_or;
            op_xori:  op = alu_xor;
            op_lui:   op = alu_lui;
            op_beq:   br = br_eq;
            op_bne:   br = br_ne;
            default:  op = alu_nop;
        endcase
    end

    assign is_rtype = opcode == op_special;
    // logic immediates zero-extend, arithmetic and branch offsets sign-extend
    assign sign_ext = opcode inside {op_addiu, op_slti, op_beq, op_bne};
    // branches compare rs against rt, so b stays a register
    assign use_imm  = !is_rtype && br == br_none;
    assign imm      = sign_ext ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
    assign waddr    = is_rtype ? rd_addr : rt_addr;

    assign opnd_a = fwd_mux(fwd_a, rf_rdata_a, exec_wdata, retire_wdata);
    assign opnd_b = use_imm ? imm : fwd_mux(fwd_b, rf_rdata_b, exec_wdata, retire_wdata);

    // squash drops the instruction behind a taken branch
    always_ff @(posedge clk) begin
        if (rst) begin
            de_valid <= 1'b0;
        end else begin
            de_valid <= fd_valid && !squash;
        end
    end

    always_ff @(posedge clk) begin
        de_pc      <= fd_pc;
        de_op      <= op;
        de_br      <= br;
        de_src_a   <= opnd_a;
        de_src_b   <= opnd_b;
        de_imm_sel <= imm;
        de_waddr   <= waddr;
        // no write for r0, branches or unknown encodings
        de_we      <= op != alu_nop && waddr != 5'd0;
    end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/10ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      de_valid,
    input  word_t     de_pc,
    input  alu_op_t   de_op,
    input  br_kind_t  de_br,
    input  word_t     de_src_a,
    input  word_t     de_src_b,
    input  word_t     de_imm_sel,
    input  reg_addr_t de_waddr,
    input  logic      de_we,
    output logic      exec_valid,
    output reg_addr_t exec_waddr,
    output logic      exec_we,
    output word_t     exec_wdata,
    output logic      redirect,
    output word_t     redirect_pc,
    output logic      er_valid,
    output word_t     er_pc,
    output logic      er_we,
    output reg_addr_t er_waddr,
    output word_t     er_wdata
);

    word_t result;
    logic  taken;

    always_comb begin
        case (de_op)
            alu_add:  result = de_src_a + de_src_b;
            alu_sub:  result = de_src_a - de_src_b;
            alu_and:  result = de_src_a & de_src_b;
            alu_or:   result = de_src_a | de_src_b;
            alu_xor:  result = de_src_a ^ de_src_b;
            alu_nor:  result = ~(de_src_a | de_src_b);
            alu_slt:  result = {31'd0, $signed(de_src_a) < $signed(de_src_b)};
            alu_sltu: result = {31'd0, de_src_a < de_src_b};
            alu_lui:  result = {de_src_b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    always_comb begin
        case (de_br)
            br_eq:   taken = de_src_a == de_src_b;
            br_ne:   taken = de_src_a != de_src_b;
            default: taken = 1'b0;
        endcase
    end

    // no delay slot so the target is relative to the branch's own pc+4
    assign redirect    = de_valid && taken;
    assign redirect_pc = de_pc + 32'd4 + {de_imm_sel[29:0], 2'b00};

    // result seen by the bypass network in the same cycle
    assign exec_valid = de_valid;
    assign exec_waddr = de_waddr;
    assign exec_we    = de_we;
    assign exec_wdata = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            er_valid <= 1'b0;
        end else begin
            er_valid <= de_valid;
        end
    end

    always_ff @(posedge clk) begin
        er_pc    <= de_pc;
        er_we    <= de_we;
        er_waddr <= de_waddr;
        er_wdata <= result;
    end

    // the cycle after a redirect the younger decode slot must have been squashed
    assert property (@(posedge clk) disable iff (rst)
                     $past(redirect) |-> !de_valid)
        else $error("execute_stage: redirect without squash of the next instruction");

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage import isa_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  ihit,
    input  word_t idata,
    input  logic  redirect,
    input  word_t redirect_pc,
    output word_t iaddr,
    output logic  fd_valid,
    output word_t fd_pc,
    output word_t fd_instr
);

    word_t pc;

    assign iaddr = pc;

    // a taken branch overrides whatever is being fetched this cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= RESET_PC;
            fd_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= redirect_pc;
            fd_valid <= 1'b0;
        end else if (ihit) begin
            pc       <= pc + 32'd4;
            fd_valid <= 1'b1;
        end else begin
            fd_valid <= 1'b0;
        end
    end

    // instruction word and its pc
    always_ff @(posedge clk) begin
        if (ihit) begin
            fd_pc    <= pc;
            fd_instr <= idata;
        end
    end

    // branch targets come back from execute and must stay aligned
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("fetch_stage: pc %h not word aligned", pc);

endmodule

//--- src/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // primary opcode, instr[31:26]
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;

    // funct field under op_special, instr[5:0]
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // alu_nop marks branches and anything not decoded
    typedef enum logic [3:0] {
        alu_nop,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_lui
    } alu_op_t;

endpackage

//--- src/pipe_pkg.sv
package pipe_pkg;

    // operand source picked by the bypass network
    typedef enum logic [1:0] {
        fwd_rf,
        fwd_exec,
        fwd_retire
    } fwd_src_t;

    typedef enum logic [1:0] {
        br_none,
        br_eq,
        br_ne
    } br_kind_t;

endpackage

//--- src/regfile.sv
`timescale 1ns/10ps

module regfile import isa_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,
    output word_t     rf_rdata_a,
    output word_t     rf_rdata_b
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // r0 reads as zero
    assign rf_rdata_a = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
    assign rf_rdata_b = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

endmodule

//--- src/retire_stage.sv
`timescale 1ns/10ps

module retire_stage import isa_pkg::*; (
    input  logic      er_valid,
    input  word_t     er_pc,
    input  logic      er_we,
    input  reg_addr_t er_waddr,
    input  word_t     er_wdata,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,
    output logic      retire_valid,
    output word_t     retire_pc,
    output logic      retire_we,
    output reg_addr_t retire_waddr,
    output word_t     retire_wdata
);

    // only a valid slot may touch the register file
    assign rf_we    = er_valid && er_we;
    assign rf_waddr = er_waddr;
    assign rf_wdata = er_wdata;

    // retire report mirrors the write
    assign retire_valid = er_valid;
    assign retire_pc    = er_pc;
    assign retire_we    = rf_we;
    assign retire_waddr = er_waddr;
    assign retire_wdata = er_wdata;

endmodule
